/* Bender.yml */
package:
  name: acc_dispatcher

sources:
  - src/acc_disp_pkg.sv
  - src/acc_disp_ctrl.sv
  - src/acc_insn_queue.sv
  - src/acc_spec_tracker.sv
  - src/acc_req_reg.sv
  - src/acc_mem_tracker.sv
  - src/acc_dispatcher.sv
  - target: test
    files:
      - tests/tb_clk_gen.sv
      - tests/tb_acc_dispatcher.sv

/* flist.f */
src/acc_disp_pkg.sv
src/acc_disp_ctrl.sv
src/acc_insn_queue.sv
src/acc_spec_tracker.sv
src/acc_req_reg.sv
src/acc_mem_tracker.sv
src/acc_dispatcher.sv
tests/tb_clk_gen.sv
tests/tb_acc_dispatcher.sv

/* src/acc_disp_ctrl.sv */
// Dispatcher control
`timescale 1ns/1ps

module acc_disp_ctrl import acc_disp_pkg::*; (
  input  logic                                      clk_i,
  input  logic                                      arst_n_i,
  input  logic                                      issue_hs_i,
  input  logic                                      issue_ex_valid_i,
  input  logic [FU_W-1:0]                           issue_fu_i,
  input  logic                                      flush_unissued_i,
  input  logic                                      acc_cons_en_i,
  input  logic [QUEUE_CNT_W-1:0]                    queue_usage_i,
  input  logic                                      no_ld_pending_i,
  input  logic                                      no_st_pending_i,
  input  logic [NR_COMMIT_PORTS-1:0]                commit_ex_valid_i,
  input  logic [NR_COMMIT_PORTS-1:0][FU_W-1:0]      commit_fu_i,
  input  logic [NR_COMMIT_PORTS-1:0][TRANS_ID_W-1:0] commit_trans_id_i,
  input  logic [NR_COMMIT_PORTS-1:0]                commit_ack_i,
  input  logic                                      commit_st_barrier_i,
  input  logic                                      acc_store_pending_i,
  output logic                                      acc_valid_d_o,
  output logic                                      acc_valid_ex_o,
  output logic                                      issue_stall_o,
  output logic                                      commit_o,
  output logic [TRANS_ID_W-1:0]                     commit_trans_id_o,
  output logic                                      ctrl_halt_o,
  output logic                                      dirty_v_state_o
);

  logic acc_valid_q;
  logic wait_st_q;

  // Accelerator instruction accepted by issue and not killed
  assign acc_valid_d_o = issue_hs_i && !issue_ex_valid_i &&
                         (issue_fu_i == FU_ACCEL) && !flush_unissued_i;
  assign acc_valid_ex_o = acc_valid_q;

  // Operands follow one cycle later
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      acc_valid_q <= 1'b0;
    end else begin
      acc_valid_q <= acc_valid_d_o;
    end
  end

  // Issue stall
  always_comb begin
    case (issue_fu_i)
      // Queue must keep one slot for the instruction already in flight
      FU_ACCEL: issue_stall_o = queue_usage_i >= QUEUE_CNT_W'(INSN_QUEUE_DEPTH - 1);
      // Scalar load behind an accelerator store
      FU_LOAD:  issue_stall_o = acc_cons_en_i && !no_st_pending_i;
      // Scalar store behind any accelerator memory access
      FU_STORE: issue_stall_o = acc_cons_en_i && (!no_st_pending_i || !no_ld_pending_i);
      default:  issue_stall_o = 1'b0;
    endcase
  end

  // First unexecuted entry at the commit head is non-speculative
  assign commit_o = (!commit_ex_valid_i[0] && (commit_fu_i[0] == FU_ACCEL)) ||
                    (commit_ex_valid_i[0] && !commit_ex_valid_i[1] &&
                     (commit_fu_i[1] == FU_ACCEL));
  assign commit_trans_id_o = commit_ex_valid_i[0] ? commit_trans_id_i[1]
                                                  : commit_trans_id_i[0];

  // Any acknowledged accelerator commit touches vector state
  always_comb begin
    dirty_v_state_o = 1'b0;
    for (int p = 0; p < NR_COMMIT_PORTS; p++) begin
      dirty_v_state_o |= commit_ack_i[p] && (commit_fu_i[p] == FU_ACCEL);
    end
  end

  // Store barrier: halt until the accelerator drains its stores
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wait_st_q <= 1'b0;
    end else begin
      wait_st_q <= (wait_st_q || commit_st_barrier_i) && acc_store_pending_i;
    end
  end

  assign ctrl_halt_o = wait_st_q;

endmodule

/* src/acc_disp_pkg.sv */
// Accelerator dispatcher definitions
package acc_disp_pkg;

  // Scoreboard transaction ids
  localparam int unsigned TRANS_ID_W    = 3;
  localparam int unsigned NR_SB_ENTRIES = 2 ** TRANS_ID_W;

  // Datapath widths
  localparam int unsigned XLEN   = 64;
  localparam int unsigned INSN_W = 32;
  localparam int unsigned FRM_W  = 3;

  // Function-unit codes as seen at issue and commit
  localparam int unsigned    FU_W     = 2;
  localparam logic [FU_W-1:0] FU_NONE  = 2'd0;
  localparam logic [FU_W-1:0] FU_LOAD  = 2'd1;
  localparam logic [FU_W-1:0] FU_STORE = 2'd2;
  localparam logic [FU_W-1:0] FU_ACCEL = 2'd3;

  // Accelerator operation classes, used for memory tracking
  localparam int unsigned     OP_W         = 2;
  localparam logic [OP_W-1:0] ACC_OP_OTHER = 2'd0;
  localparam logic [OP_W-1:0] ACC_OP_LOAD  = 2'd1;
  localparam logic [OP_W-1:0] ACC_OP_STORE = 2'd2;

  // Instruction queue
  localparam int unsigned INSN_QUEUE_DEPTH = 3;
  localparam int unsigned QUEUE_CNT_W      = 2;

  // Load and store counters
  localparam int unsigned MEM_CNT_W = 3;

  // Commit window
  localparam int unsigned NR_COMMIT_PORTS = 2;

endpackage

/* src/acc_dispatcher.sv */
// Accelerator dispatcher top level
`timescale 1ns/1ps

module acc_dispatcher import acc_disp_pkg::*; (
  input  logic                                       clk_i,
  input  logic                                       arst_n_i,
  input  logic                                       acc_cons_en_i,
  input  logic [FRM_W-1:0]                           fcsr_frm_i,
  input  logic                                       issue_hs_i,
  input  logic                                       issue_ex_valid_i,
  input  logic [FU_W-1:0]                            issue_fu_i,
  input  logic [OP_W-1:0]                            issue_op_i,
  input  logic [INSN_W-1:0]                          issue_insn_i,
  input  logic [XLEN-1:0]                            issue_rs1_i,
  input  logic [XLEN-1:0]                            issue_rs2_i,
  input  logic [TRANS_ID_W-1:0]                      issue_trans_id_i,
  input  logic                                       flush_unissued_i,
  input  logic                                       flush_ex_i,
  input  logic [NR_COMMIT_PORTS-1:0]                 commit_ex_valid_i,
  input  logic [NR_COMMIT_PORTS-1:0][FU_W-1:0]       commit_fu_i,
  input  logic [NR_COMMIT_PORTS-1:0][TRANS_ID_W-1:0] commit_trans_id_i,
  input  logic [NR_COMMIT_PORTS-1:0]                 commit_ack_i,
  input  logic                                       commit_st_barrier_i,
  input  logic                                       acc_no_st_pending_i,
  input  logic                                       acc_req_ready_i,
  input  logic                                       acc_load_complete_i,
  input  logic                                       acc_store_complete_i,
  input  logic                                       acc_store_pending_i,
  output logic                                       issue_stall_o,
  output logic                                       acc_valid_ex_o,
  output logic                                       ctrl_halt_o,
  output logic                                       dirty_v_state_o,
  output logic                                       acc_req_valid_o,
  output logic [INSN_W-1:0]                          acc_req_insn_o,
  output logic [XLEN-1:0]                            acc_req_rs1_o,
  output logic [XLEN-1:0]                            acc_req_rs2_o,
  output logic [FRM_W-1:0]                           acc_req_frm_o,
  output logic [TRANS_ID_W-1:0]                      acc_req_trans_id_o,
  output logic                                       acc_req_store_pending_o
);

  logic                   acc_valid_d;
  logic [OP_W-1:0]        op_q;
  logic [QUEUE_CNT_W-1:0] q_usage;
  logic                   q_empty;
  logic [INSN_W-1:0]      q_insn;
  logic [XLEN-1:0]        q_rs1;
  logic [XLEN-1:0]        q_rs2;
  logic [TRANS_ID_W-1:0]  q_tid;
  logic [OP_W-1:0]        q_op;
  logic                   no_ld_pending;
  logic                   no_st_pending;
  logic                   commit;
  logic [TRANS_ID_W-1:0]  commit_tid;
  logic                   head_ready;
  logic                   req_ready;
  logic                   disp;

  // Operation class travels with the operands, one cycle after issue
  always_ff @(posedge clk_i) begin
    if (acc_valid_d) begin
      op_q <= issue_op_i;
    end
  end

  // Non-speculative head moves on when the request register has room
  assign disp = !q_empty && head_ready && req_ready;

  assign acc_req_store_pending_o = acc_cons_en_i && !acc_no_st_pending_i;

  acc_disp_ctrl u_acc_disp_ctrl (
    .clk_i               (clk_i),
    .arst_n_i            (arst_n_i),
    .issue_hs_i          (issue_hs_i),
    .issue_ex_valid_i    (issue_ex_valid_i),
    .issue_fu_i          (issue_fu_i),
    .flush_unissued_i    (flush_unissued_i),
    .acc_cons_en_i       (acc_cons_en_i),
    .queue_usage_i       (q_usage),
    .no_ld_pending_i     (no_ld_pending),
    .no_st_pending_i     (no_st_pending),
    .commit_ex_valid_i   (commit_ex_valid_i),
    .commit_fu_i         (commit_fu_i),
    .commit_trans_id_i   (commit_trans_id_i),
    .commit_ack_i        (commit_ack_i),
    .commit_st_barrier_i (commit_st_barrier_i),
    .acc_store_pending_i (acc_store_pending_i),
    .acc_valid_d_o       (acc_valid_d),
    .acc_valid_ex_o      (acc_valid_ex_o),
    .issue_stall_o       (issue_stall_o),
    .commit_o            (commit),
    .commit_trans_id_o   (commit_tid),
    .ctrl_halt_o         (ctrl_halt_o),
    .dirty_v_state_o     (dirty_v_state_o)
  );

  acc_insn_queue u_acc_insn_queue (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .flush_i    (flush_ex_i),
    .push_i     (acc_valid_ex_o),
    .insn_i     (issue_insn_i),
    .rs1_i      (issue_rs1_i),
    .rs2_i      (issue_rs2_i),
    .trans_id_i (issue_trans_id_i),
    .op_i       (op_q),
    .pop_i      (disp),
    .insn_o     (q_insn),
    .rs1_o      (q_rs1),
    .rs2_o      (q_rs2),
    .trans_id_o (q_tid),
    .op_o       (q_op),
    .empty_o    (q_empty),
    .usage_o    (q_usage)
  );

  acc_spec_tracker u_acc_spec_tracker (
    .clk_i             (clk_i),
    .arst_n_i          (arst_n_i),
    .flush_i           (flush_ex_i),
    .recv_i            (acc_valid_ex_o),
    .recv_trans_id_i   (issue_trans_id_i),
    .commit_i          (commit),
    .commit_trans_id_i (commit_tid),
    .disp_i            (disp),
    .disp_trans_id_i   (q_tid),
    .head_trans_id_i   (q_tid),
    .head_ready_o      (head_ready)
  );

  // Rounding mode is sampled when the request leaves the queue
  acc_req_reg u_acc_req_reg (
    .clk_i              (clk_i),
    .arst_n_i           (arst_n_i),
    .valid_i            (disp),
    .insn_i             (q_insn),
    .rs1_i              (q_rs1),
    .rs2_i              (q_rs2),
    .frm_i              (fcsr_frm_i),
    .trans_id_i         (q_tid),
    .acc_req_ready_i    (acc_req_ready_i),
    .ready_o            (req_ready),
    .acc_req_valid_o    (acc_req_valid_o),
    .acc_req_insn_o     (acc_req_insn_o),
    .acc_req_rs1_o      (acc_req_rs1_o),
    .acc_req_rs2_o      (acc_req_rs2_o),
    .acc_req_frm_o      (acc_req_frm_o),
    .acc_req_trans_id_o (acc_req_trans_id_o)
  );

  acc_mem_tracker u_acc_mem_tracker (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .flush_i          (flush_ex_i),
    .issue_valid_i    (acc_valid_d),
    .issue_op_i       (issue_op_i),
    .disp_i           (disp),
    .disp_op_i        (q_op),
    .load_complete_i  (acc_load_complete_i),
    .store_complete_i (acc_store_complete_i),
    .no_ld_pending_o  (no_ld_pending),
    .no_st_pending_o  (no_st_pending)
  );

endmodule

/* src/acc_insn_queue.sv */
// Accelerator instruction queue
`timescale 1ns/1ps

module acc_insn_queue import acc_disp_pkg::*; (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   flush_i,
  input  logic                   push_i,
  input  logic [INSN_W-1:0]      insn_i,
  input  logic [XLEN-1:0]        rs1_i,
  input  logic [XLEN-1:0]        rs2_i,
  input  logic [TRANS_ID_W-1:0]  trans_id_i,
  input  logic [OP_W-1:0]        op_i,
  input  logic                   pop_i,
  output logic [INSN_W-1:0]      insn_o,
  output logic [XLEN-1:0]        rs1_o,
  output logic [XLEN-1:0]        rs2_o,
  output logic [TRANS_ID_W-1:0]  trans_id_o,
  output logic [OP_W-1:0]        op_o,
  output logic                   empty_o,
  output logic [QUEUE_CNT_W-1:0] usage_o
);

  // Entry storage
  logic [INSN_W-1:0]     insn_mem [INSN_QUEUE_DEPTH];
  logic [XLEN-1:0]       rs1_mem  [INSN_QUEUE_DEPTH];
  logic [XLEN-1:0]       rs2_mem  [INSN_QUEUE_DEPTH];
  logic [TRANS_ID_W-1:0] tid_mem  [INSN_QUEUE_DEPTH];
  logic [OP_W-1:0]       op_mem   [INSN_QUEUE_DEPTH];

  logic [QUEUE_CNT_W-1:0] rd_ptr_q;
  logic [QUEUE_CNT_W-1:0] wr_ptr_q;
  logic [QUEUE_CNT_W-1:0] cnt_q;
  logic                   full;
  logic                   bypass;
  logic                   do_push;
  logic                   do_pop;

  assign full    = cnt_q == QUEUE_CNT_W'(INSN_QUEUE_DEPTH);
  // Empty queue shows the incoming entry directly
  assign bypass  = (cnt_q == '0) && push_i;
  assign empty_o = (cnt_q == '0) && !push_i;
  assign usage_o = cnt_q;

  assign insn_o     = bypass ? insn_i     : insn_mem[rd_ptr_q];
  assign rs1_o      = bypass ? rs1_i      : rs1_mem[rd_ptr_q];
  assign rs2_o      = bypass ? rs2_i      : rs2_mem[rd_ptr_q];
  assign trans_id_o = bypass ? trans_id_i : tid_mem[rd_ptr_q];
  assign op_o       = bypass ? op_i       : op_mem[rd_ptr_q];

  // A bypassed entry popped in the same cycle is never stored
  assign do_push = push_i && !full && !(bypass && pop_i);
  assign do_pop  = pop_i && (cnt_q != '0);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      // Pointers wrap at the last slot
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == QUEUE_CNT_W'(INSN_QUEUE_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == QUEUE_CNT_W'(INSN_QUEUE_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (!do_push && do_pop) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // Payload write
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      insn_mem[wr_ptr_q] <= insn_i;
      rs1_mem[wr_ptr_q]  <= rs1_i;
      rs2_mem[wr_ptr_q]  <= rs2_i;
      tid_mem[wr_ptr_q]  <= trans_id_i;
      op_mem[wr_ptr_q]   <= op_i;
    end
  end

endmodule

/* src/acc_mem_tracker.sv */
// Accelerator load and store counters
`timescale 1ns/1ps

module acc_mem_tracker import acc_disp_pkg::*; (
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  logic            flush_i,
  input  logic            issue_valid_i,
  input  logic [OP_W-1:0] issue_op_i,
  input  logic            disp_i,
  input  logic [OP_W-1:0] disp_op_i,
  input  logic            load_complete_i,
  input  logic            store_complete_i,
  output logic            no_ld_pending_o,
  output logic            no_st_pending_o
);

  // Index 0 tracks loads, index 1 tracks stores
  logic [MEM_CNT_W-1:0] spec_cnt_q [2];
  logic [MEM_CNT_W-1:0] disp_cnt_q [2];
  logic [1:0]           issue_hit;
  logic [1:0]           disp_hit;
  logic [1:0]           done;

  assign issue_hit[0] = issue_valid_i && (issue_op_i == ACC_OP_LOAD);
  assign issue_hit[1] = issue_valid_i && (issue_op_i == ACC_OP_STORE);
  assign disp_hit[0]  = disp_i && (disp_op_i == ACC_OP_LOAD);
  assign disp_hit[1]  = disp_i && (disp_op_i == ACC_OP_STORE);
  assign done[0]      = load_complete_i;
  assign done[1]      = store_complete_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      spec_cnt_q <= '{default: '0};
      disp_cnt_q <= '{default: '0};
    end else begin
      for (int k = 0; k < 2; k++) begin
        // Speculative accesses can still be flushed
        if (flush_i) begin
          spec_cnt_q[k] <= '0;
        end else if (issue_hit[k] && !disp_hit[k]) begin
          spec_cnt_q[k] <= spec_cnt_q[k] + 1'b1;
        end else if (!issue_hit[k] && disp_hit[k]) begin
          spec_cnt_q[k] <= spec_cnt_q[k] - 1'b1;
        end
        // Dispatched ones wait for the accelerator to complete
        if (disp_hit[k] && !done[k]) begin
          disp_cnt_q[k] <= disp_cnt_q[k] + 1'b1;
        end else if (!disp_hit[k] && done[k]) begin
          disp_cnt_q[k] <= disp_cnt_q[k] - 1'b1;
        end
      end
    end
  end

  assign no_ld_pending_o = (spec_cnt_q[0] == '0) && (disp_cnt_q[0] == '0);
  assign no_st_pending_o = (spec_cnt_q[1] == '0) && (disp_cnt_q[1] == '0);

endmodule

/* src/acc_req_reg.sv */
// Accelerator request register
`timescale 1ns/1ps

module acc_req_reg import acc_disp_pkg::*; (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  valid_i,
  input  logic [INSN_W-1:0]     insn_i,
  input  logic [XLEN-1:0]       rs1_i,
  input  logic [XLEN-1:0]       rs2_i,
  input  logic [FRM_W-1:0]      frm_i,
  input  logic [TRANS_ID_W-1:0] trans_id_i,
  input  logic                  acc_req_ready_i,
  output logic                  ready_o,
  output logic                  acc_req_valid_o,
  output logic [INSN_W-1:0]     acc_req_insn_o,
  output logic [XLEN-1:0]       acc_req_rs1_o,
  output logic [XLEN-1:0]       acc_req_rs2_o,
  output logic [FRM_W-1:0]      acc_req_frm_o,
  output logic [TRANS_ID_W-1:0] acc_req_trans_id_o
);

  logic                  full_q;
  logic                  capture;
  logic [INSN_W-1:0]     insn_q;
  logic [XLEN-1:0]       rs1_q;
  logic [XLEN-1:0]       rs2_q;
  logic [FRM_W-1:0]      frm_q;
  logic [TRANS_ID_W-1:0] tid_q;

  // Hold a request the accelerator did not take
  assign capture = !full_q && valid_i && !acc_req_ready_i;
  assign ready_o = !full_q;

  // Empty register passes the request straight through
  assign acc_req_valid_o    = full_q || valid_i;
  assign acc_req_insn_o     = full_q ? insn_q : insn_i;
  assign acc_req_rs1_o      = full_q ? rs1_q  : rs1_i;
  assign acc_req_rs2_o      = full_q ? rs2_q  : rs2_i;
  assign acc_req_frm_o      = full_q ? frm_q  : frm_i;
  assign acc_req_trans_id_o = full_q ? tid_q  : trans_id_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      full_q <= 1'b0;
    end else if (full_q) begin
      // Drains on the transfer edge
      full_q <= !acc_req_ready_i;
    end else begin
      full_q <= capture;
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture) begin
      insn_q <= insn_i;
      rs1_q  <= rs1_i;
      rs2_q  <= rs2_i;
      frm_q  <= frm_i;
      tid_q  <= trans_id_i;
    end
  end

endmodule

/* src/acc_spec_tracker.sv */
// Speculation tracker
`timescale 1ns/1ps

module acc_spec_tracker import acc_disp_pkg::*; (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  flush_i,
  input  logic                  recv_i,
  input  logic [TRANS_ID_W-1:0] recv_trans_id_i,
  input  logic                  commit_i,
  input  logic [TRANS_ID_W-1:0] commit_trans_id_i,
  input  logic                  disp_i,
  input  logic [TRANS_ID_W-1:0] disp_trans_id_i,
  input  logic [TRANS_ID_W-1:0] head_trans_id_i,
  output logic                  head_ready_o
);

  // Pending: received, still speculative. Ready: reached the commit head
  logic [NR_SB_ENTRIES-1:0] pending_q;
  logic [NR_SB_ENTRIES-1:0] pending_d;
  logic [NR_SB_ENTRIES-1:0] ready_q;
  logic [NR_SB_ENTRIES-1:0] ready_d;
  logic                     commit_hit;

  // Only ids we actually received count as committed here
  assign commit_hit = commit_i && pending_q[commit_trans_id_i];

  // Commit in this very cycle already lets the head go
  assign head_ready_o = ready_q[head_trans_id_i] || commit_hit;

  always_comb begin
    pending_d = pending_q;
    ready_d   = ready_q;
    if (recv_i) begin
      pending_d[recv_trans_id_i] = 1'b1;
    end
    if (flush_i) begin
      pending_d = '0;
    end
    // Move from pending to ready
    if (commit_hit) begin
      pending_d[commit_trans_id_i] = 1'b0;
      ready_d[commit_trans_id_i]   = 1'b1;
    end
    if (disp_i) begin
      ready_d[disp_trans_id_i] = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pending_q <= '0;
      ready_q   <= '0;
    end else begin
      pending_q <= pending_d;
      ready_q   <= ready_d;
    end
  end

endmodule

/* tests/tb_acc_dispatcher.sv */
// Accelerator dispatcher testbench
`timescale 1ns/1ps

module tb_acc_dispatcher import acc_disp_pkg::*; ();

  localparam int NUM_TESTS  = 6;
  localparam int TEST_LEN   = 120;
  localparam int DRAIN_MAX  = 70;
  localparam int CLK_PERIOD = 4;

  logic clk_i, arst_n_i, acc_cons_en_i, issue_hs_i, issue_ex_valid_i;
  logic flush_unissued_i, flush_ex_i, commit_st_barrier_i, acc_no_st_pending_i;
  logic acc_req_ready_i, acc_load_complete_i, acc_store_complete_i, acc_store_pending_i;
  logic [FRM_W-1:0] fcsr_frm_i;
  logic [FU_W-1:0] issue_fu_i;
  logic [OP_W-1:0] issue_op_i;
  logic [INSN_W-1:0] issue_insn_i;
  logic [XLEN-1:0] issue_rs1_i, issue_rs2_i;
  logic [TRANS_ID_W-1:0] issue_trans_id_i;
  logic [NR_COMMIT_PORTS-1:0] commit_ex_valid_i, commit_ack_i;
  logic [NR_COMMIT_PORTS-1:0][FU_W-1:0] commit_fu_i;
  logic [NR_COMMIT_PORTS-1:0][TRANS_ID_W-1:0] commit_trans_id_i;
  logic issue_stall_o, acc_valid_ex_o, ctrl_halt_o, dirty_v_state_o, acc_req_valid_o;
  logic acc_req_store_pending_o;
  logic [INSN_W-1:0] acc_req_insn_o;
  logic [XLEN-1:0] acc_req_rs1_o, acc_req_rs2_o;
  logic [FRM_W-1:0] acc_req_frm_o;
  logic [TRANS_ID_W-1:0] acc_req_trans_id_o;

  // Reference model state
  logic [INSN_W-1:0] m_insn [$];
  logic [XLEN-1:0] m_rs1 [$];
  logic [XLEN-1:0] m_rs2 [$];
  logic [TRANS_ID_W-1:0] m_tid [$];
  logic [OP_W-1:0] m_op [$];
  logic [TRANS_ID_W-1:0] commit_q [$];
  logic [NR_SB_ENTRIES-1:0] m_pending, m_ready;
  logic m_reg_full, m_halt, m_issued, inflight;
  logic [INSN_W-1:0] r_insn;
  logic [XLEN-1:0] r_rs1, r_rs2;
  logic [FRM_W-1:0] r_frm;
  logic [TRANS_ID_W-1:0] r_tid, next_tid, f_tid;
  logic [OP_W-1:0] m_op_prev;
  logic [INSN_W-1:0] f_insn;
  logic [XLEN-1:0] f_rs1, f_rs2;
  int spec_ld, spec_st, disp_ld, disp_st;
  int pushes, dropped, transfers, errors, checks;
  int ready_pct, flush_pct, cons_mode, barrier_pct;

  tb_clk_gen u_tb_clk_gen (.clk_o(clk_i), .arst_n_o(arst_n_i));

  acc_dispatcher u_acc_dispatcher (.*);

  // Run limit derived from the test lengths
  initial begin
    #(CLK_PERIOD * (NUM_TESTS * 200 + 100));
    $display("Watchdog expired before the tests finished");
    $display("Test failed");
    $finish;
  end

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_req(input logic [INSN_W-1:0] insn, input logic [XLEN-1:0] rs1,
                           input logic [XLEN-1:0] rs2, input logic [FRM_W-1:0] frm,
                           input logic [TRANS_ID_W-1:0] tid);
    checks++;
    if (acc_req_insn_o !== insn || acc_req_rs1_o !== rs1 || acc_req_rs2_o !== rs2 ||
        acc_req_frm_o !== frm || acc_req_trans_id_o !== tid) begin
      errors++;
      // Fields in order insn, rs1, rs2, frm, trans_id
      $display("[FAIL] %0t acc_req fields got %h/%h/%h/%0d/%0d expected %h/%h/%h/%0d/%0d",
               $time, acc_req_insn_o, acc_req_rs1_o, acc_req_rs2_o, acc_req_frm_o,
               acc_req_trans_id_o, insn, rs1, rs2, frm, tid);
    end
  endtask

  function automatic logic stall_pred(input logic [FU_W-1:0] fu);
    logic no_ld;
    logic no_st;
    no_ld = (spec_ld == 0) && (disp_ld == 0);
    no_st = (spec_st == 0) && (disp_st == 0);
    case (fu)
      FU_ACCEL: return m_insn.size() >= INSN_QUEUE_DEPTH - 1;
      FU_LOAD:  return acc_cons_en_i && !no_st;
      FU_STORE: return acc_cons_en_i && (!no_st || !no_ld);
      default:  return 1'b0;
    endcase
  endfunction

  // Random inputs for one cycle, kept legal for the core side
  task automatic drive_inputs(input bit drain);
    bit opnd;
    opnd = inflight;
    inflight = 1'b0;
    acc_cons_en_i = (cons_mode == 2) ? 1'($urandom) : 1'(cons_mode);
    acc_no_st_pending_i = $urandom;
    fcsr_frm_i = $urandom;
    issue_hs_i = 1'b0;
    issue_ex_valid_i = ($urandom % 8 == 0);
    issue_fu_i = $urandom;
    issue_op_i = $urandom % 3;
    flush_unissued_i = ($urandom % 10 == 0);
    flush_ex_i = 1'b0;
    issue_insn_i = $urandom;
    issue_rs1_i = {$urandom, $urandom};
    issue_rs2_i = {$urandom, $urandom};
    issue_trans_id_i = $urandom;
    if (opnd) begin
      // Operands follow the issue by one cycle
      issue_insn_i = f_insn;
      issue_rs1_i = f_rs1;
      issue_rs2_i = f_rs2;
      issue_trans_id_i = f_tid;
    end else if (!drain && ($urandom % 3 == 0)) begin
      if (issue_fu_i == FU_ACCEL) begin
        if (!stall_pred(FU_ACCEL)) begin
          issue_hs_i = 1'b1;
          issue_ex_valid_i = 1'b0;
          if (!flush_unissued_i) begin
            inflight = 1'b1;
            f_insn = $urandom;
            f_rs1 = {$urandom, $urandom};
            f_rs2 = {$urandom, $urandom};
            f_tid = next_tid;
            next_tid++;
            commit_q.push_back(f_tid);
          end
        end
      end else begin
        issue_hs_i = !stall_pred(issue_fu_i);
      end
    end
    if (!drain && !opnd && !inflight && ($urandom % 100 < flush_pct)) begin
      flush_ex_i = 1'b1;
      commit_q.delete();
    end
    commit_ex_valid_i = $urandom;
    commit_ack_i = $urandom;
    for (int p = 0; p < NR_COMMIT_PORTS; p++) begin
      commit_fu_i[p] = $urandom % 3;
      commit_trans_id_i[p] = $urandom;
    end
    if (!flush_ex_i && commit_q.size() > 0 && m_pending[commit_q[0]] &&
        (drain || $urandom % 3 == 0)) begin
      // Either port may hold the first unexecuted entry
      if ($urandom % 2) begin
        commit_ex_valid_i[0] = 1'b0;
        commit_fu_i[0] = FU_ACCEL;
        commit_trans_id_i[0] = commit_q.pop_front();
      end else begin
        commit_ex_valid_i = 2'b01;
        commit_fu_i[1] = FU_ACCEL;
        commit_trans_id_i[1] = commit_q.pop_front();
      end
    end
    acc_req_ready_i = drain || ($urandom % 100 < ready_pct);
    acc_load_complete_i = (disp_ld > 0) && ($urandom % 4 == 0);
    acc_store_complete_i = (disp_st > 0) && ($urandom % 4 == 0);
    commit_st_barrier_i = ($urandom % 100 < barrier_pct);
    if ($urandom % 6 == 0) acc_store_pending_i = !acc_store_pending_i;
  endtask

  // Sample before the edge, predict, then advance the model
  task automatic step_cycle();
    logic has_head, commit, hit, head_rdy, disp, exp_valid, dirty, push, fl, bypass;
    logic [TRANS_ID_W-1:0] ctid, h_tid;
    logic [INSN_W-1:0] h_insn;
    logic [XLEN-1:0] h_rs1, h_rs2;
    logic [OP_W-1:0] h_op;
    #2;
    push = m_issued;
    fl = flush_ex_i;
    check_bit("acc_valid_ex_o", acc_valid_ex_o, push);
    has_head = (m_insn.size() > 0) || push;
    // Empty queue hands the incoming entry straight to its head
    bypass = push && (m_insn.size() == 0);
    h_insn = (m_insn.size() > 0) ? m_insn[0] : issue_insn_i;
    h_rs1 = (m_insn.size() > 0) ? m_rs1[0] : issue_rs1_i;
    h_rs2 = (m_insn.size() > 0) ? m_rs2[0] : issue_rs2_i;
    h_tid = (m_insn.size() > 0) ? m_tid[0] : issue_trans_id_i;
    h_op = (m_insn.size() > 0) ? m_op[0] : m_op_prev;
    commit = (!commit_ex_valid_i[0] && commit_fu_i[0] == FU_ACCEL) ||
             (commit_ex_valid_i == 2'b01 && commit_fu_i[1] == FU_ACCEL);
    ctid = commit_ex_valid_i[0] ? commit_trans_id_i[1] : commit_trans_id_i[0];
    hit = commit && m_pending[ctid];
    head_rdy = has_head && (m_ready[h_tid] || hit);
    disp = head_rdy && !m_reg_full;
    exp_valid = m_reg_full || disp;
    check_bit("acc_req_valid_o", acc_req_valid_o, exp_valid);
    if (exp_valid && m_reg_full) check_req(r_insn, r_rs1, r_rs2, r_frm, r_tid);
    if (exp_valid && !m_reg_full) check_req(h_insn, h_rs1, h_rs2, fcsr_frm_i, h_tid);
    dirty = 1'b0;
    for (int p = 0; p < NR_COMMIT_PORTS; p++) begin
      dirty |= commit_ack_i[p] && (commit_fu_i[p] == FU_ACCEL);
    end
    check_bit("dirty_v_state_o", dirty_v_state_o, dirty);
    check_bit("issue_stall_o", issue_stall_o, stall_pred(issue_fu_i));
    check_bit("ctrl_halt_o", ctrl_halt_o, m_halt);
    check_bit("acc_req_store_pending_o", acc_req_store_pending_o,
              acc_cons_en_i && !acc_no_st_pending_i);
    // Requests the accelerator actually took
    if (acc_req_valid_o && acc_req_ready_i) transfers++;
    // Model update for the coming edge
    // Halt drops once stores drain, a barrier raises it while stores remain
    if (!acc_store_pending_i) begin
      m_halt = 1'b0;
    end else if (commit_st_barrier_i) begin
      m_halt = 1'b1;
    end
    if (push) begin
      pushes++;
      m_pending[issue_trans_id_i] = 1'b1;
    end
    if (fl) m_pending = '0;
    if (hit) begin
      m_pending[ctid] = 1'b0;
      m_ready[ctid] = 1'b1;
    end
    if (disp) m_ready[h_tid] = 1'b0;
    if (m_reg_full) begin
      m_reg_full = !acc_req_ready_i;
    end else if (disp && !acc_req_ready_i) begin
      m_reg_full = 1'b1;
      {r_insn, r_rs1, r_rs2, r_frm, r_tid} = {h_insn, h_rs1, h_rs2, fcsr_frm_i, h_tid};
    end
    if (disp && m_insn.size() > 0) begin
      void'(m_insn.pop_front());
      void'(m_rs1.pop_front());
      void'(m_rs2.pop_front());
      void'(m_tid.pop_front());
      void'(m_op.pop_front());
    end
    // A bypassed entry dispatched at once is never stored
    if (push && !(bypass && disp)) begin
      m_insn.push_back(issue_insn_i);
      m_rs1.push_back(issue_rs1_i);
      m_rs2.push_back(issue_rs2_i);
      m_tid.push_back(issue_trans_id_i);
      m_op.push_back(m_op_prev);
    end
    if (fl) begin
      dropped += m_insn.size();
      m_insn.delete();
      m_rs1.delete();
      m_rs2.delete();
      m_tid.delete();
      m_op.delete();
    end
    if (fl) begin
      spec_ld = 0;
      spec_st = 0;
    end else begin
      spec_ld += (m_issued_now() && issue_op_i == ACC_OP_LOAD) - (disp && h_op == ACC_OP_LOAD);
      spec_st += (m_issued_now() && issue_op_i == ACC_OP_STORE) - (disp && h_op == ACC_OP_STORE);
    end
    disp_ld += (disp && h_op == ACC_OP_LOAD) - acc_load_complete_i;
    disp_st += (disp && h_op == ACC_OP_STORE) - acc_store_complete_i;
    m_issued = m_issued_now();
    m_op_prev = issue_op_i;
    @(posedge clk_i);
    #1;
  endtask

  function automatic logic m_issued_now();
    return issue_hs_i && !issue_ex_valid_i && (issue_fu_i == FU_ACCEL) && !flush_unissued_i;
  endfunction

  task automatic run_test(input string name, input int rdy, input int fl, input int cons,
                          input int bar);
    int e0;
    int n;
    e0 = errors;
    ready_pct = rdy;
    flush_pct = fl;
    cons_mode = cons;
    barrier_pct = bar;
    repeat (TEST_LEN) begin
      drive_inputs(1'b0);
      step_cycle();
    end
    n = 0;
    while ((commit_q.size() > 0 || inflight || m_issued || m_insn.size() > 0 || m_reg_full)
           && n < DRAIN_MAX) begin
      drive_inputs(1'b1);
      step_cycle();
      n++;
    end
    if (n >= DRAIN_MAX) begin
      errors++;
      $display("Queued requests were not drained within %0d cycles", DRAIN_MAX);
    end
    check_count("transferred requests", transfers, pushes - dropped);
    $display("test %s finished with %0d errors", name, errors - e0);
  endtask

  initial begin
    void'($urandom(91));
    {acc_cons_en_i, issue_hs_i, issue_ex_valid_i, flush_unissued_i, flush_ex_i} = '0;
    {commit_st_barrier_i, acc_no_st_pending_i, acc_req_ready_i} = '0;
    {acc_load_complete_i, acc_store_complete_i, acc_store_pending_i} = '0;
    {fcsr_frm_i, issue_fu_i, issue_op_i, issue_insn_i, issue_rs1_i, issue_rs2_i} = '0;
    {issue_trans_id_i, commit_ex_valid_i, commit_ack_i, commit_fu_i, commit_trans_id_i} = '0;
    {m_pending, m_ready, m_reg_full, m_halt, m_issued, inflight, next_tid, m_op_prev} = '0;
    {spec_ld, spec_st, disp_ld, disp_st, pushes, dropped, transfers, errors, checks} = '0;
    @(posedge arst_n_i);
    @(posedge clk_i);
    #1;
    run_test("request order", 100, 0, 0, 0);
    run_test("back-pressure", 40, 0, 0, 0);
    run_test("flush", 70, 4, 0, 0);
    run_test("consistency stall", 60, 0, 2, 0);
    run_test("store barrier", 70, 0, 1, 8);
    run_test("dirty state", 80, 2, 1, 3);
    $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* tests/tb_clk_gen.sv */
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic arst_n_o
);

  localparam real HALF_PERIOD = 2.0;

  initial begin
    clk_o    = 1'b0;
    arst_n_o = 1'b0;
    // Reset held for five rising edges
    repeat (5) @(posedge clk_o);
    #1 arst_n_o = 1'b1;
  end

  always #(HALF_PERIOD) clk_o = ~clk_o;

endmodule
